/* verilog/bus_pkg.sv */
package bus_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Sizes
   ////////////////////////////////////////////////////////////////////////////

   localparam int QUEUE_DEPTH = 4;                       // Also the sender's starting credits
   localparam int REG_COUNT   = 4;                       // Octal registers on the bus
   localparam int PTR_W       = $clog2(QUEUE_DEPTH);     // Depth is a power of two
   localparam int CNT_W       = $clog2(QUEUE_DEPTH + 1); // Holds 0 to QUEUE_DEPTH

   ////////////////////////////////////////////////////////////////////////////
   // Opcodes and sequencer states
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      OP_NOP   = 3'd0,   // Walks the phases and touches nothing
      OP_LOAD  = 3'd1,   // Immediate to dst
      OP_MOVE  = 3'd2,   // src to dst
      OP_MOVN  = 3'd3,   // Inverted src to dst
      OP_CLEAR = 3'd4,   // dst to zero
      OP_JK    = 3'd5    // Flag operation
   } bus_op_e;

   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_DRIVE = 2'd1,   // Sources on the bus
      ST_LATCH = 2'd2    // Bus settled, loads strobed
   } seq_state_e;

   ////////////////////////////////////////////////////////////////////////////
   // Bundles
   ////////////////////////////////////////////////////////////////////////////

   // Command word, 15 bits
   typedef struct packed {
      bus_op_e    op;
      logic [1:0] dst;    // Register, or flag select in bit 0 for OP_JK
      logic [1:0] src;
      logic [7:0] data;   // Immediate, or J in bit 1 and K in bit 0
   } bus_cmd_t;

   // Sequencer to register bank
   typedef struct packed {
      logic [REG_COUNT-1:0] src_oe;   // One-hot
      logic                 invert;   // Inverting read path
      logic                 imm_oe;
      logic [7:0]           imm;
      logic [REG_COUNT-1:0] load;     // One-hot
      logic [REG_COUNT-1:0] clear;    // One-hot
   } bank_ctrl_t;

   // Sequencer to JK flags
   typedef struct packed {
      logic strobe;
      logic sel;
      logic j;
      logic k;
   } flag_ctrl_t;

   // Bank register outputs
   typedef struct packed {
      logic [7:0] r3;
      logic [7:0] r2;
      logic [7:0] r1;
      logic [7:0] r0;
   } reg_view_t;

endpackage

/* verilog/cmd_queue.sv */
`timescale 1ns/1ns

module cmd_queue import bus_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  logic     cmd_valid,
   input  bus_cmd_t cmd_data,
   input  logic     q_pop,
   output bus_cmd_t q_cmd,
   output logic     q_empty,
   output logic     cmd_credit
);

   ////////////////////////////////////////////////////////////////////////////
   // Storage and pointers
   ////////////////////////////////////////////////////////////////////////////

   bus_cmd_t         mem [QUEUE_DEPTH];   // Circular buffer, no reset
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;               // Occupancy
   logic             full;
   logic             push;
   logic             pop;

   assign full    = (count == CNT_W'(QUEUE_DEPTH));
   assign q_empty = (count == '0);
   assign q_cmd   = mem[rd_ptr];          // Head entry, read combinationally

   // A send while full is a sender fault and is dropped here
   assign push = cmd_valid && !full;
   assign pop  = q_pop && !q_empty;

   // Payload write
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= cmd_data;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Control state
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         cmd_credit <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;   // Wraps at QUEUE_DEPTH
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
         // One credit back per consumed entry, one cycle late
         cmd_credit <= pop;
      end
   end

endmodule

/* verilog/bus_sequencer.sv */
`timescale 1ns/1ns

module bus_sequencer import bus_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  bus_cmd_t   q_cmd,
   input  logic       q_empty,
   output logic       q_pop,
   output bank_ctrl_t bank_ctrl,
   output flag_ctrl_t flag_ctrl,
   output logic       idle
);

   ////////////////////////////////////////////////////////////////////////////
   // State register, a small clearable D bank
   ////////////////////////////////////////////////////////////////////////////

   seq_state_e           state;
   seq_state_e           state_nxt;
   bus_cmd_t             cur_cmd;     // Command being executed
   logic                 active;      // DRIVE or LATCH
   logic                 latch;       // Last cycle of a command
   logic [REG_COUNT-1:0] dst_hot;
   logic [REG_COUNT-1:0] src_hot;

   always_ff @(posedge clk) begin
      if (!rst) begin
         state   <= ST_IDLE;
         cur_cmd <= '0;
      end else begin
         state <= state_nxt;
         if (q_pop) begin
            cur_cmd <= q_cmd;   // Capture head on the pop edge
         end
      end
   end

   // IDLE -> DRIVE -> LATCH -> IDLE
   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (!q_empty) begin
               state_nxt = ST_DRIVE;
            end
         end
         ST_DRIVE: state_nxt = ST_LATCH;
         ST_LATCH: state_nxt = ST_IDLE;
         default:  state_nxt = ST_IDLE;   // Unused encoding
      endcase
   end

   assign q_pop = (state == ST_IDLE) && !q_empty;   // Pop only from IDLE
   assign idle  = (state == ST_IDLE) && q_empty;

   ////////////////////////////////////////////////////////////////////////////
   // Opcode decode
   ////////////////////////////////////////////////////////////////////////////

   assign active  = (state == ST_DRIVE) || (state == ST_LATCH);
   assign latch   = (state == ST_LATCH);
   assign dst_hot = REG_COUNT'(1) << cur_cmd.dst;
   assign src_hot = REG_COUNT'(1) << cur_cmd.src;

   always_comb begin
      bank_ctrl = '0;
      flag_ctrl = '0;
      if (active) begin
         case (cur_cmd.op)
            OP_LOAD: begin
               bank_ctrl.imm_oe = 1'b1;
               bank_ctrl.imm    = cur_cmd.data;
               bank_ctrl.load   = latch ? dst_hot : '0;
            end
            OP_MOVE: begin
               bank_ctrl.src_oe = src_hot;
               bank_ctrl.load   = latch ? dst_hot : '0;
            end
            OP_MOVN: begin
               bank_ctrl.src_oe = src_hot;
               bank_ctrl.invert = 1'b1;   // Read through the inverting path
               bank_ctrl.load   = latch ? dst_hot : '0;
            end
            OP_CLEAR: begin
               // Nothing on the bus, clear bit only
               bank_ctrl.clear = latch ? dst_hot : '0;
            end
            OP_JK: begin
               flag_ctrl.strobe = latch;
               flag_ctrl.sel    = cur_cmd.dst[0];
               flag_ctrl.j      = cur_cmd.data[1];
               flag_ctrl.k      = cur_cmd.data[0];
            end
            default: begin
               // OP_NOP and spare codes drive no enables
               bank_ctrl = '0;
            end
         endcase
      end
   end

endmodule

/* verilog/register_bank.sv */
`timescale 1ns/1ns

module register_bank import bus_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  bank_ctrl_t bank_ctrl,
   output reg_view_t  regs
);

   ////////////////////////////////////////////////////////////////////////////
   // Shared bus
   ////////////////////////////////////////////////////////////////////////////

   logic [7:0] r [REG_COUNT];   // Octal registers
   logic [7:0] bus;             // OR of all enabled drivers

   // Tristate drivers become an enable-gated OR
   always_comb begin
      bus = bank_ctrl.imm_oe ? bank_ctrl.imm : 8'h00;
      for (int i = 0; i < REG_COUNT; i++) begin
         if (bank_ctrl.src_oe[i]) begin
            // Inverting read path like the x564
            bus = bus | (bank_ctrl.invert ? ~r[i] : r[i]);
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Registers, clearable like the x273
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            r[i] <= 8'h00;
         end
      end else begin
         for (int i = 0; i < REG_COUNT; i++) begin
            if (bank_ctrl.clear[i]) begin
               r[i] <= 8'h00;   // Clear wins over load
            end else if (bank_ctrl.load[i]) begin
               // Bus holds the old value when src equals dst
               r[i] <= bus;
            end
         end
      end
   end

   // Register outputs
   assign regs.r0 = r[0];
   assign regs.r1 = r[1];
   assign regs.r2 = r[2];
   assign regs.r3 = r[3];

endmodule

/* verilog/jk_flags.sv */
`timescale 1ns/1ns

module jk_flags import bus_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  flag_ctrl_t flag_ctrl,
   output logic [1:0] flag_q,
   output logic [1:0] flag_qn
);

   logic [1:0] q_nxt;

   ////////////////////////////////////////////////////////////////////////////
   // JK table on strobe, like the x112
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      q_nxt = flag_q;
      if (flag_ctrl.strobe) begin
         case ({flag_ctrl.j, flag_ctrl.k})
            2'b01:   q_nxt[flag_ctrl.sel] = 1'b0;                   // Reset
            2'b10:   q_nxt[flag_ctrl.sel] = 1'b1;                   // Set
            2'b11:   q_nxt[flag_ctrl.sel] = ~flag_q[flag_ctrl.sel]; // Toggle
            default: q_nxt[flag_ctrl.sel] = flag_q[flag_ctrl.sel];  // Hold
         endcase
      end
   end

   // Q and /Q as separate flops, always complementary
   always_ff @(posedge clk) begin
      if (!rst) begin
         flag_q  <= 2'b00;
         flag_qn <= 2'b11;
      end else begin
         flag_q  <= q_nxt;
         flag_qn <= ~q_nxt;
      end
   end

endmodule

/* verilog/bus_board.sv */
`timescale 1ns/1ns

module bus_board import bus_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       cmd_valid,     // Only while holding a credit
   input  bus_cmd_t   cmd_data,
   output logic       cmd_credit,    // One credit per pulse
   output logic       idle,
   output reg_view_t  regs,
   output logic [1:0] flag_q,
   output logic [1:0] flag_qn
);

   ////////////////////////////////////////////////////////////////////////////
   // Internal wiring
   ////////////////////////////////////////////////////////////////////////////

   bus_cmd_t   q_cmd;
   logic       q_empty;
   logic       q_pop;
   bank_ctrl_t bank_ctrl;
   flag_ctrl_t flag_ctrl;

   // Command queue on the credit link
   cmd_queue u_queue (
      .clk        (clk),
      .rst        (rst),
      .cmd_valid  (cmd_valid),
      .cmd_data   (cmd_data),
      .q_pop      (q_pop),
      .q_cmd      (q_cmd),
      .q_empty    (q_empty),
      .cmd_credit (cmd_credit)
   );

   // Three-cycle command sequencer
   bus_sequencer u_seq (
      .clk       (clk),
      .rst       (rst),
      .q_cmd     (q_cmd),
      .q_empty   (q_empty),
      .q_pop     (q_pop),
      .bank_ctrl (bank_ctrl),
      .flag_ctrl (flag_ctrl),
      .idle      (idle)
   );

   register_bank u_bank (
      .clk       (clk),
      .rst       (rst),
      .bank_ctrl (bank_ctrl),
      .regs      (regs)
   );

   jk_flags u_flags (
      .clk       (clk),
      .rst       (rst),
      .flag_ctrl (flag_ctrl),
      .flag_q    (flag_q),
      .flag_qn   (flag_qn)
   );

endmodule

/* testbench/bus_board_chk.sv */
`timescale 1ns/1ns

module bus_board_chk import bus_pkg::*; (
   input logic       clk,
   input logic       rst,
   input logic       cmd_valid,
   input logic       cmd_credit,
   input logic       q_pop,
   input bank_ctrl_t bank_ctrl,
   input logic [1:0] flag_q,
   input logic [1:0] flag_qn
);

   logic [CNT_W-1:0] occ;    // Queue occupancy seen from the ports
   logic             full;

   assign full = (occ == CNT_W'(QUEUE_DEPTH));

   always_ff @(posedge clk) begin
      if (!rst) begin
         occ <= '0;
      end else begin
         case ({cmd_valid && !full, q_pop})
            2'b10:   occ <= occ + 1'b1;
            2'b01:   occ <= occ - 1'b1;
            default: occ <= occ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Link, control encoding and flag outputs
   ////////////////////////////////////////////////////////////////////////////

   a_no_send_full: assert property (@(posedge clk) disable iff (!rst)
      cmd_valid |-> !full) else $error("command sent into a full queue");

   a_load_onehot: assert property (@(posedge clk) disable iff (!rst)
      $onehot0(bank_ctrl.load)) else $error("bank load not one-hot");

   a_clear_onehot: assert property (@(posedge clk) disable iff (!rst)
      $onehot0(bank_ctrl.clear)) else $error("bank clear not one-hot");

   a_flag_compl: assert property (@(posedge clk) disable iff (!rst)
      flag_qn == ~flag_q) else $error("flag_qn is not the complement of flag_q");

   // Back to back credits need back to back pops
   a_credit_pops: assert property (@(posedge clk) disable iff (!rst)
      (cmd_credit && $past(cmd_credit)) |-> ($past(q_pop) && $past(q_pop, 2)))
      else $error("two credits without two pops");

endmodule

bind bus_board bus_board_chk u_chk (
   .clk        (clk),
   .rst        (rst),
   .cmd_valid  (cmd_valid),
   .cmd_credit (cmd_credit),
   .q_pop      (q_pop),
   .bank_ctrl  (bank_ctrl),
   .flag_q     (flag_q),
   .flag_qn    (flag_qn)
);

/* testbench/tb_bus_board.sv */
`timescale 1ns/1ns

module tb_bus_board import bus_pkg::*; ();

   localparam int WAIT_LIMIT = 200;   // Cycles per wait loop
   localparam int SEED       = 61585;

   logic       clk;
   logic       rst;
   logic       cmd_valid;
   bus_cmd_t   cmd_data;
   logic       cmd_credit;
   logic       idle;
   reg_view_t  regs;
   logic [1:0] flag_q;
   logic [1:0] flag_qn;

   int         errors;
   int         sent_count;       // Driver side only
   int         credit_returns;   // Monitor side only
   logic       timed_out;        // Rest of the run is skipped
   logic [7:0] m_regs [REG_COUNT];
   logic [1:0] m_q;              // Model flags

   bus_board u_dut (
      .clk        (clk),
      .rst        (rst),
      .cmd_valid  (cmd_valid),
      .cmd_data   (cmd_data),
      .cmd_credit (cmd_credit),
      .idle       (idle),
      .regs       (regs),
      .flag_q     (flag_q),
      .flag_qn    (flag_qn)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 125 MHz
   end

   // Credit pulses, sampled on the edge
   always @(posedge clk) begin
      if (rst && cmd_credit) begin
         credit_returns = credit_returns + 1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reference model and checks
   ////////////////////////////////////////////////////////////////////////////

   function automatic int credits_left();
      return QUEUE_DEPTH - sent_count + credit_returns;
   endfunction

   function automatic bus_cmd_t make_cmd(input bus_op_e op);
      bus_cmd_t c;
      c.op   = op;
      c.dst  = 2'($urandom_range(0, 3));
      c.src  = 2'($urandom_range(0, 3));
      c.data = 8'($urandom);
      return c;
   endfunction

   // Commands retire in send order
   task automatic apply_model(input bus_cmd_t c);
      case (c.op)
         OP_LOAD:  m_regs[c.dst] = c.data;
         OP_MOVE:  m_regs[c.dst] = m_regs[c.src];
         OP_MOVN:  m_regs[c.dst] = ~m_regs[c.src];
         OP_CLEAR: m_regs[c.dst] = 8'h00;
         OP_JK: begin
            case (c.data[1:0])
               2'b01:   m_q[c.dst[0]] = 1'b0;            // K only
               2'b10:   m_q[c.dst[0]] = 1'b1;            // J only
               2'b11:   m_q[c.dst[0]] = ~m_q[c.dst[0]];  // Toggle
               default: m_q[c.dst[0]] = m_q[c.dst[0]];
            endcase
         end
         default: m_q = m_q;   // NOP
      endcase
   endtask

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic compare_all();
      logic [1:0] exp_qn;
      exp_qn = ~m_q;   // Kept 2 bits wide
      if (!timed_out) begin
         check_val("regs.r0", regs.r0, m_regs[0]);
         check_val("regs.r1", regs.r1, m_regs[1]);
         check_val("regs.r2", regs.r2, m_regs[2]);
         check_val("regs.r3", regs.r3, m_regs[3]);
         check_val("flag_q", flag_q, m_q);
         check_val("flag_qn", flag_qn, exp_qn);
         check_val("credits", credits_left(), QUEUE_DEPTH);    // All back at idle
         check_val("credit pulses", credit_returns, sent_count);
      end
   endtask

   task automatic note_timeout(input string why);
      errors++;
      timed_out = 1'b1;
      $display("%0t %s", $time, why);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   // Entered and left 1 ns after an edge
   task automatic send_cmd(input bus_cmd_t c);
      int cycles;
      cycles = 0;
      if (!timed_out) begin
         while (credits_left() == 0 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
         end
         if (credits_left() == 0) begin
            note_timeout("no credit came back from the DUT in time");
         end else begin
            cmd_valid = 1'b1;
            cmd_data  = c;
            sent_count++;   // One credit spent
            apply_model(c);
            @(posedge clk);
            #1;
            cmd_valid = 1'b0;
         end
      end
   endtask

   task automatic wait_idle();
      int cycles;
      cycles = 0;
      if (!timed_out) begin
         while (!idle && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
         end
         if (!idle) begin
            note_timeout("the DUT did not return to idle in time");
         end
      end
   endtask

   // kind 0 load or clear, 1 move or inverted move, else any opcode
   task automatic random_bursts(input int kind, input int bursts);
      bus_cmd_t c;
      int       len;
      for (int b = 0; b < bursts; b++) begin
         len = $urandom_range(1, QUEUE_DEPTH);
         for (int i = 0; i < len; i++) begin
            case (kind)
               0: c = make_cmd(($urandom_range(0, 3) == 0) ? OP_CLEAR : OP_LOAD);
               1: begin
                  c = make_cmd(($urandom_range(0, 1) == 1) ? OP_MOVN : OP_MOVE);
                  if ($urandom_range(0, 3) == 0) begin
                     c.src = c.dst;   // Reads the old value
                  end
               end
               default: c = make_cmd(bus_op_e'($urandom_range(0, 5)));
            endcase
            send_cmd(c);
         end
         wait_idle();
         compare_all();
      end
   endtask

   initial begin
      bus_cmd_t c;
      void'($urandom(SEED));
      errors         = 0;
      sent_count     = 0;
      credit_returns = 0;
      timed_out      = 1'b0;
      m_q            = 2'b00;
      for (int i = 0; i < REG_COUNT; i++) begin
         m_regs[i] = 8'h00;
      end
      rst       = 1'b0;
      cmd_valid = 1'b0;
      cmd_data  = '0;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b1;

      // Reset state, quiet link
      repeat (4) @(posedge clk);
      #1;
      check_val("idle", idle, 1'b1);
      compare_all();

      random_bursts(0, 12);   // Loads and clears
      for (int i = 0; i < REG_COUNT; i++) begin
         c      = make_cmd(OP_LOAD);
         c.dst  = 2'(i);
         c.data = 8'(8'h11 * (i + 1) + $urandom_range(0, 15));
         send_cmd(c);
      end
      wait_idle();
      compare_all();
      random_bursts(1, 16);   // Moves

      // JK table on both flags, each case from both starting states
      for (int f = 0; f < 2; f++) begin
         for (int jk = 0; jk < 4; jk++) begin
            for (int start = 0; start < 2; start++) begin
               c           = make_cmd(OP_JK);
               c.dst       = 2'(f);
               c.data[1:0] = (start == 1) ? 2'b10 : 2'b01;   // Preset by set or reset
               send_cmd(c);
               c.data[1:0] = 2'(jk);
               send_cmd(c);
               wait_idle();
               compare_all();
            end
         end
      end
      repeat (QUEUE_DEPTH) send_cmd(make_cmd(OP_NOP));
      wait_idle();
      compare_all();

      // Continuous stream, stalls on credits
      repeat (40) send_cmd(make_cmd(bus_op_e'($urandom_range(0, 5))));
      wait_idle();
      compare_all();

      random_bursts(2, 60);   // Long mix

      $display("errors %0d, commands sent %0d, credits returned %0d",
               errors, sent_count, credit_returns);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* files.f */
verilog/bus_pkg.sv
verilog/cmd_queue.sv
verilog/bus_sequencer.sv
verilog/register_bank.sv
verilog/jk_flags.sv
verilog/bus_board.sv
testbench/bus_board_chk.sv
testbench/tb_bus_board.sv

/* Makefile */
VERILATOR  = verilator
TOP        = tb_bus_board
FILELIST   = files.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/1ns -Wno-fatal
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ns -Wall
PASS_MSG   = all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
